//--- rtl/rsa_pkg.sv
package rsa_pkg;

    // word width of matrix elements, accumulators and sums
    parameter int RSA_DW = 16;

    // all arithmetic wraps at RSA_DW bits
    typedef logic [RSA_DW-1:0] data_t;

    // output adder mode, sampled with i_cal_done
    typedef enum logic [1:0] {
        MODE_PASS = 2'd0,   // C = A*B
        MODE_ADD  = 2'd1,   // C = A*B + M
        MODE_SUB  = 2'd2    // C = M - A*B, covariance style update
    } add_mode_t;

    // drain sequencer
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_SETTLE = 2'd1,   // last step still travelling through the grid
        ST_DRAIN  = 2'd2    // accumulators shifting west, one column per cycle
    } drain_state_t;

endpackage

//--- rtl/pe_mac.sv
module pe_mac import rsa_pkg::*; (
    input  logic  clk,
    input  logic  i_rst_n,
    input  logic  i_clear,     // start of a new product
    input  logic  i_val,
    input  data_t i_west,      // A operand from the west
    input  data_t i_south,     // B operand from the south
    input  logic  i_shift,     // drain strobe
    input  data_t i_east_acc,  // east neighbour's accumulator
    output logic  o_val,
    output data_t o_east,
    output data_t o_north,
    output data_t o_acc
);

    data_t acc;
    data_t west_q;
    data_t south_q;
    logic  val_q;
    data_t prod;

    // low half of the product only
    assign prod = data_t'(i_west * i_south);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            acc   <= '0;
            val_q <= 1'b0;
        end else begin
            val_q <= i_val;
            if (i_clear) begin
                acc <= '0;
            end else if (i_shift) begin
                acc <= i_east_acc;          // move one column west
            end else if (i_val) begin
                acc <= acc + prod;
            end
        end
    end

    // operands hop one PE per cycle
    always_ff @(posedge clk) begin
        west_q  <= i_west;
        south_q <= i_south;
    end

    assign o_val   = val_q;
    assign o_east  = west_q;
    assign o_north = south_q;
    assign o_acc   = acc;

    // the drain may only start once the last step has left every PE
    a_no_mac_during_drain: assert property (
        @(posedge clk) disable iff (!i_rst_n) !(i_val && i_shift)
    ) else $error("pe_mac: accumulate and drain shift in the same cycle");

endmodule

//--- rtl/pe_array.sv
module pe_array import rsa_pkg::*; #(
    parameter int X = 3,
    parameter int Y = 3
) (
    input  logic          clk,
    input  logic          i_rst_n,
    input  logic          i_start,
    input  logic          i_ab_val,
    input  data_t [X-1:0] i_a_col,
    input  data_t [Y-1:0] i_b_row,
    input  logic          i_shift,
    output data_t [X-1:0] o_drain_col
);

    data_t [X-1:0] a_skew;   // west edge operands, row i delayed i+1 cycles
    logic  [X-1:0] v_skew;
    data_t [Y-1:0] b_skew;   // south edge operands, column j delayed j+1 cycles

    // grid nets, indexed by the PE that drives them
    data_t east_w  [X][Y];
    data_t north_w [X][Y];
    logic  val_w   [X][Y];
    data_t acc_w   [X][Y];

    // row staircase, valid rides along with A
    for (genvar i = 0; i < X; i++) begin : g_a_skew
        localparam int DEPTH = i + 1;
        localparam int AW    = DEPTH * RSA_DW;
        data_t [DEPTH-1:0] a_pipe;
        logic  [DEPTH-1:0] v_pipe;

        always_ff @(posedge clk or negedge i_rst_n) begin
            if (!i_rst_n) begin
                v_pipe <= '0;
            end else begin
                v_pipe <= DEPTH'({v_pipe, i_ab_val});
            end
        end

        always_ff @(posedge clk) begin
            a_pipe <= AW'({a_pipe, i_a_col[i]});
        end

        assign a_skew[i] = a_pipe[DEPTH-1];
        assign v_skew[i] = v_pipe[DEPTH-1];
    end

    // column staircase for B
    for (genvar j = 0; j < Y; j++) begin : g_b_skew
        localparam int DEPTH = j + 1;
        localparam int BW    = DEPTH * RSA_DW;
        data_t [DEPTH-1:0] b_pipe;

        always_ff @(posedge clk) begin
            b_pipe <= BW'({b_pipe, i_b_row[j]});
        end

        assign b_skew[j] = b_pipe[DEPTH-1];
    end

    for (genvar i = 0; i < X; i++) begin : g_row
        for (genvar j = 0; j < Y; j++) begin : g_col
            data_t west_in;
            logic  val_in;
            data_t south_in;
            data_t east_acc;

            if (j == 0) begin : g_west_edge
                assign west_in = a_skew[i];
                assign val_in  = v_skew[i];
            end else begin : g_west_pe
                assign west_in = east_w[i][j-1];
                assign val_in  = val_w[i][j-1];
            end

            if (i == 0) begin : g_south_edge
                assign south_in = b_skew[j];
            end else begin : g_south_pe
                assign south_in = north_w[i-1][j];
            end

            if (j == Y - 1) begin : g_east_edge
                assign east_acc = '0;       // zero fills in from the east
            end else begin : g_east_pe
                assign east_acc = acc_w[i][j+1];
            end

            pe_mac u_pe (
                .clk        (clk),
                .i_rst_n    (i_rst_n),
                .i_clear    (i_start),
                .i_val      (val_in),
                .i_west     (west_in),
                .i_south    (south_in),
                .i_shift    (i_shift),
                .i_east_acc (east_acc),
                .o_val      (val_w[i][j]),
                .o_east     (east_w[i][j]),
                .o_north    (north_w[i][j]),
                .o_acc      (acc_w[i][j])
            );
        end

        assign o_drain_col[i] = acc_w[i][0];
    end

endmodule

//--- rtl/m_col_buffer.sv
module m_col_buffer import rsa_pkg::*; #(
    parameter int X = 3,
    parameter int Y = 3
) (
    input  logic          clk,
    input  logic          i_rst_n,
    input  logic          i_start,
    input  logic          i_m_wr,
    input  data_t [X-1:0] i_m_col,
    input  logic          i_m_rd,
    output data_t [X-1:0] o_m_col
);

    localparam int WPW = $clog2(Y + 1);   // write pointer also counts "full"
    localparam int RPW = $clog2(Y);

    data_t [X-1:0]  mem [Y];
    logic [WPW-1:0] wr_ptr;
    logic [RPW-1:0] rd_ptr;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (i_start) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (i_m_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (i_m_rd) begin
                // wraps after the last column of a drain
                rd_ptr <= (rd_ptr == RPW'(Y - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_m_wr) begin
            mem[wr_ptr[RPW-1:0]] <= i_m_col;
        end
    end

    assign o_m_col = mem[rd_ptr];   // combinational read

    a_no_overfill: assert property (
        @(posedge clk) disable iff (!i_rst_n) i_m_wr |-> (wr_ptr < WPW'(Y))
    ) else $error("m_col_buffer: M column written with all %0d columns stored", Y);

endmodule

//--- rtl/drain_adder.sv
module drain_adder import rsa_pkg::*; #(
    parameter int X = 3,
    parameter int Y = 3
) (
    input  logic          clk,
    input  logic          i_rst_n,
    input  logic          i_cal_done,
    input  add_mode_t     i_mode,
    input  data_t [X-1:0] i_drain_col,
    input  data_t [X-1:0] i_m_col,
    output logic          o_shift,
    output logic          o_m_rd,
    output logic          o_busy,
    output logic          o_c_val,
    output data_t [X-1:0] o_c_col
);

    localparam int CW = $clog2(X + Y);

    drain_state_t  state;
    add_mode_t     mode_q;
    logic [CW-1:0] cnt;
    logic          drain;
    logic          c_val_q;
    data_t [X-1:0] sum;
    data_t [X-1:0] c_col_q;

    assign drain = (state == ST_DRAIN);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state   <= ST_IDLE;
            mode_q  <= MODE_PASS;
            cnt     <= '0;
            c_val_q <= 1'b0;
        end else begin
            c_val_q <= drain;   // sums appear one cycle behind the shift
            case (state)
                ST_IDLE: begin
                    if (i_cal_done) begin
                        state  <= ST_SETTLE;
                        mode_q <= i_mode;
                        cnt    <= CW'(X + Y - 1);   // wait for the far corner PE
                    end
                end
                ST_SETTLE: begin
                    if (cnt == '0) begin
                        state <= ST_DRAIN;
                        cnt   <= CW'(Y - 1);
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                ST_DRAIN: begin
                    if (cnt == '0) begin
                        state <= ST_IDLE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // per row combine with M
    always_comb begin
        for (int r = 0; r < X; r++) begin
            case (mode_q)
                MODE_ADD: sum[r] = i_drain_col[r] + i_m_col[r];
                MODE_SUB: sum[r] = i_m_col[r] - i_drain_col[r];
                default:  sum[r] = i_drain_col[r];
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (drain) begin
            c_col_q <= sum;
        end
    end

    assign o_shift = drain;
    assign o_m_rd  = drain;
    assign o_c_val = c_val_q;
    assign o_c_col = c_col_q;
    // held through the last output column
    assign o_busy  = (state != ST_IDLE) || c_val_q;

    a_cal_done_idle: assert property (
        @(posedge clk) disable iff (!i_rst_n) i_cal_done |-> (state == ST_IDLE)
    ) else $error("drain_adder: i_cal_done while a product is still draining");

endmodule

//--- rtl/rsa_top.sv
module rsa_top import rsa_pkg::*; #(
    parameter int X = 3,
    parameter int Y = 3
) (
    input  logic          clk,
    input  logic          i_rst_n,
    input  logic          i_start,
    input  logic          i_ab_val,
    input  data_t [X-1:0] i_a_col,    // A[i][k], one column per step
    input  data_t [Y-1:0] i_b_row,    // B[k][j], one row per step
    input  logic          i_cal_done,
    input  add_mode_t     i_mode,
    input  logic          i_m_wr,
    input  data_t [X-1:0] i_m_col,
    output logic          o_busy,
    output logic          o_c_val,
    output data_t [X-1:0] o_c_col
);

    data_t [X-1:0] drain_col;
    data_t [X-1:0] m_col_rd;
    logic          shift;
    logic          m_rd;

    pe_array #(
        .X (X),
        .Y (Y)
    ) u_array (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .i_ab_val    (i_ab_val),
        .i_a_col     (i_a_col),
        .i_b_row     (i_b_row),
        .i_shift     (shift),
        .o_drain_col (drain_col)
    );

    m_col_buffer #(
        .X (X),
        .Y (Y)
    ) u_mbuf (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_start (i_start),
        .i_m_wr  (i_m_wr),
        .i_m_col (i_m_col),
        .i_m_rd  (m_rd),
        .o_m_col (m_col_rd)
    );

    drain_adder #(
        .X (X),
        .Y (Y)
    ) u_drain (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_cal_done  (i_cal_done),
        .i_mode      (i_mode),
        .i_drain_col (drain_col),
        .i_m_col     (m_col_rd),
        .o_shift     (shift),
        .o_m_rd      (m_rd),
        .o_busy      (o_busy),
        .o_c_val     (o_c_val),
        .o_c_col     (o_c_col)
    );

endmodule

//--- tb/rsa_checker.sv
module rsa_checker import rsa_pkg::*; #(
    parameter int X     = 3,
    parameter int Y     = 3,
    parameter int K_MAX = 4
) (
    input  logic                     clk,
    input  logic                     i_rst_n,
    input  logic                     i_cal_done,
    input  int                       i_k,       // inner dimension of the case
    input  add_mode_t                i_mode,
    input  data_t [X-1:0][K_MAX-1:0] i_a,
    input  data_t [K_MAX-1:0][Y-1:0] i_b,
    input  data_t [X-1:0][Y-1:0]     i_m,
    input  logic                     i_busy,
    input  logic                     i_c_val,
    input  data_t [X-1:0]            i_c_col,
    output int                       o_mismatches,
    output int                       o_proto_errs,
    output int                       o_cases_done
);
    timeunit 1ns;
    timeprecision 100ps;

    data_t [X-1:0][Y-1:0] exp_c;
    int   edge_cnt   = 0;
    int   done_edge  = 0;
    int   col        = 0;
    int   mismatches = 0;
    int   proto_errs = 0;
    int   cases_done = 0;
    logic pending    = 1'b0;

    assign o_mismatches = mismatches;
    assign o_proto_errs = proto_errs;
    assign o_cases_done = cases_done;

    // one element of C, 16-bit wrapping arithmetic throughout
    function automatic data_t expected_word(input int r, input int c);
        data_t acc;
        acc = '0;
        for (int k = 0; k < i_k; k++) begin
            acc = acc + data_t'(i_a[r][k] * i_b[k][c]);   // low half of the product
        end
        case (i_mode)
            MODE_ADD: return acc + i_m[r][c];
            MODE_SUB: return i_m[r][c] - acc;
            default:  return acc;
        endcase
    endfunction

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    // outputs are sampled half a cycle away from the active edge
    always @(negedge clk) begin
        if (!i_rst_n) begin
            pending = 1'b0;
        end else if (!pending) begin
            if (i_busy || i_c_val) begin
                $display("%0t: o_busy or o_c_val high with no product pending", $time);
                proto_errs++;
            end
            if (i_cal_done) begin
                done_edge = edge_cnt + 1;   // the coming edge samples it
                col       = 0;
                pending   = 1'b1;
                for (int r = 0; r < X; r++) begin
                    for (int c = 0; c < Y; c++) begin
                        exp_c[r][c] = expected_word(r, c);
                    end
                end
            end
        end else begin
            if (!i_busy) begin
                $display("%0t: o_busy low before the last column was delivered", $time);
                proto_errs++;
            end
            if (i_c_val) begin
                if (col == 0 && edge_cnt - done_edge != X + Y + 1) begin
                    $display("%0t: first column came %0d cycles after i_cal_done, not %0d",
                             $time, edge_cnt - done_edge, X + Y + 1);
                    proto_errs++;
                end
                for (int r = 0; r < X; r++) begin
                    if (i_c_col[r] !== exp_c[r][col]) begin
                        $display("Mismatch at %0t: o_c_col[%0d] column %0d expected %h got %h",
                                 $time, r, col, exp_c[r][col], i_c_col[r]);
                        mismatches++;
                    end
                end
                col++;
                if (col == Y) begin
                    pending = 1'b0;
                    cases_done++;
                end
            end else if (col > 0) begin
                $display("%0t: o_c_val dropped after %0d of %0d columns", $time, col, Y);
                proto_errs++;
                pending = 1'b0;
            end else if (edge_cnt - done_edge > X + Y + 1) begin
                $display("%0t: no o_c_val within %0d cycles of i_cal_done", $time, X + Y + 1);
                proto_errs++;
                pending = 1'b0;
            end
        end
    end

endmodule

//--- tb/rsa_tb.sv
module rsa_tb import rsa_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int X           = 3;
    localparam int Y           = 3;
    localparam int K_MAX       = 4;
    localparam int NCASES      = 8;
    localparam int SEED        = 32'h2446;
    localparam int WATCHDOG_NS = (NCASES * (K_MAX + Y + X + Y + 10) + 20) * 100;

    logic          clk;
    logic          rst_n;
    logic          start;
    logic          ab_val;
    data_t [X-1:0] a_col;
    data_t [Y-1:0] b_row;
    logic          cal_done;
    add_mode_t     mode;
    logic          m_wr;
    data_t [X-1:0] m_col;
    logic          busy;
    logic          c_val;
    data_t [X-1:0] c_col;
    int            mismatches;
    int            proto_errs;
    int            cases_done;
    int            seed = SEED;

    // stimulus table, one entry per case
    int                       tab_k    [NCASES];
    add_mode_t                tab_mode [NCASES];
    data_t [X-1:0][K_MAX-1:0] tab_a    [NCASES];
    data_t [K_MAX-1:0][Y-1:0] tab_b    [NCASES];
    data_t [X-1:0][Y-1:0]     tab_m    [NCASES];

    // entry being applied, also seen by the checker
    int                       cur_k;
    add_mode_t                cur_mode;
    data_t [X-1:0][K_MAX-1:0] cur_a;
    data_t [K_MAX-1:0][Y-1:0] cur_b;
    data_t [X-1:0][Y-1:0]     cur_m;

    rsa_top #(.X(X), .Y(Y)) dut_i (
        .clk        (clk),
        .i_rst_n    (rst_n),
        .i_start    (start),
        .i_ab_val   (ab_val),
        .i_a_col    (a_col),
        .i_b_row    (b_row),
        .i_cal_done (cal_done),
        .i_mode     (mode),
        .i_m_wr     (m_wr),
        .i_m_col    (m_col),
        .o_busy     (busy),
        .o_c_val    (c_val),
        .o_c_col    (c_col)
    );

    rsa_checker #(.X(X), .Y(Y), .K_MAX(K_MAX)) checker_i (
        .clk          (clk),
        .i_rst_n      (rst_n),
        .i_cal_done   (cal_done),
        .i_k          (cur_k),
        .i_mode       (cur_mode),
        .i_a          (cur_a),
        .i_b          (cur_b),
        .i_m          (cur_m),
        .i_busy       (busy),
        .i_c_val      (c_val),
        .i_c_col      (c_col),
        .o_mismatches (mismatches),
        .o_proto_errs (proto_errs),
        .o_cases_done (cases_done)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic build_table();
        for (int c = 0; c < NCASES; c++) begin
            tab_a[c] = '0;
            tab_b[c] = '0;
            tab_m[c] = '0;
            tab_k[c] = (c < 2) ? 3 - c : (c % K_MAX) + 1;   // K runs through 1..4
            if (c < 2) begin
                tab_mode[c] = MODE_PASS;
            end else begin
                tab_mode[c] = (c % 3 == 0) ? MODE_PASS : ((c % 3 == 1) ? MODE_ADD : MODE_SUB);
            end
            for (int i = 0; i < X; i++) begin
                for (int j = 0; j < Y; j++) begin
                    tab_m[c][i][j] = data_t'($random(seed));
                end
            end
            for (int k = 0; k < tab_k[c]; k++) begin
                for (int i = 0; i < X; i++) begin
                    if (c == 0) tab_a[c][i][k] = data_t'(i == k);         // identity
                    else if (c == 1) tab_a[c][i][k] = data_t'(2 * i + k + 1);
                    else tab_a[c][i][k] = data_t'($random(seed));
                end
                for (int j = 0; j < Y; j++) begin
                    if (c == 0) tab_b[c][k][j] = data_t'(3 * k + j + 1);
                    else if (c == 1) tab_b[c][k][j] = data_t'(j - k);   // some negatives
                    else tab_b[c][k][j] = data_t'($random(seed));       // products overflow
                end
            end
        end
    endtask

    // one stray step that lands in every accumulator
    task automatic leave_partial_sums();
        ab_val = 1'b1;
        for (int i = 0; i < X; i++) begin
            a_col[i] = data_t'($random(seed));
        end
        for (int j = 0; j < Y; j++) begin
            b_row[j] = data_t'($random(seed));
        end
        next_cycle();
        ab_val = 1'b0;
        repeat (X + Y) next_cycle();   // let it reach the far corner
    endtask

    task automatic run_case(input int c);
        if (c % 2 == 1) begin
            leave_partial_sums();   // i_start has to wipe these
        end
        cur_k    = tab_k[c];
        cur_mode = tab_mode[c];
        cur_a    = tab_a[c];
        cur_b    = tab_b[c];
        cur_m    = tab_m[c];
        start    = 1'b1;
        next_cycle();
        start = 1'b0;
        for (int j = 0; j < Y; j++) begin
            m_wr = 1'b1;
            for (int i = 0; i < X; i++) begin
                m_col[i] = cur_m[i][j];
            end
            next_cycle();
        end
        m_wr = 1'b0;
        for (int k = 0; k < cur_k; k++) begin
            ab_val   = 1'b1;
            cal_done = (k == cur_k - 1);
            mode     = cur_mode;
            for (int i = 0; i < X; i++) begin
                a_col[i] = cur_a[i][k];
            end
            for (int j = 0; j < Y; j++) begin
                b_row[j] = cur_b[k][j];
            end
            next_cycle();
        end
        ab_val   = 1'b0;
        cal_done = 1'b0;
        wait (busy);
        wait (!busy);
        next_cycle();
    endtask

    initial begin
        int errs;
        rst_n    = 1'b0;
        start    = 1'b0;
        ab_val   = 1'b0;
        a_col    = '0;
        b_row    = '0;
        cal_done = 1'b0;
        mode     = MODE_PASS;
        m_wr     = 1'b0;
        m_col    = '0;
        cur_k    = 0;
        cur_mode = MODE_PASS;
        cur_a    = '0;
        cur_b    = '0;
        cur_m    = '0;
        build_table();
        repeat (5) @(posedge clk);
        #10;
        rst_n = 1'b1;
        for (int c = 0; c < NCASES; c++) begin
            run_case(c);
        end
        next_cycle();
        next_cycle();   // idle tail, outputs must stay low
        errs = mismatches + proto_errs + (NCASES - cases_done);
        if (cases_done != NCASES) begin
            $display("only %0d of %0d cases delivered a complete result", cases_done, NCASES);
        end
        $display("errors: %0d mismatches, %0d protocol, %0d cases checked of %0d",
                 mismatches, proto_errs, cases_done, NCASES);
        if (errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #WATCHDOG_NS;
        $display("watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
        $display(">>> FAIL");
        $finish;
    end

endmodule

//--- project.f
rtl/rsa_pkg.sv
rtl/pe_mac.sv
rtl/pe_array.sv
rtl/m_col_buffer.sv
rtl/drain_adder.sv
rtl/rsa_top.sv
tb/rsa_checker.sv
tb/rsa_tb.sv

//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert
TOP      := rsa_tb
FILELIST := project.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := >>> PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(TOOL), run $(TOP) and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD) and $(LOG)"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q -F -x '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
